/* ntm_cfg.svh */
`ifndef NTM_CFG_SVH
`define NTM_CFG_SVH

////////////////////////////////////////////////////////////
// Vector modular inverter build constants
////////////////////////////////////////////////////////////

// Width of element values and moduli
`define NTM_DATA_SIZE 16

// Width of vector length and element index
`define NTM_INDEX_SIZE 8

// Worst-case scalar inverter latency, START to READY
// Each binary Euclid step shrinks u*v by at least half,
// so 2*DATA_SIZE steps cover any operand pair, plus
// the load and result cycles and some slack
`define NTM_STEP_BOUND (2 * `NTM_DATA_SIZE + 4)

`endif

/* ntm_pkg.sv */
`include "ntm_cfg.svh"

package ntm_pkg;

  ////////////////////////////////////////////////////////////
  // Stream payloads
  ////////////////////////////////////////////////////////////

  // One vector element with its own modulus
  typedef struct packed {
    logic [`NTM_DATA_SIZE-1:0] modulo;
    logic [`NTM_DATA_SIZE-1:0] value;
  } ntm_elem_t;

  // One inverse result
  // no_inverse set for gcd != 1 or modulo below 2,
  // value is then forced to zero
  typedef struct packed {
    logic                      no_inverse;
    logic [`NTM_DATA_SIZE-1:0] value;
  } ntm_result_t;

  ////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////

  // IDLE         waiting for START
  // WAIT_ELEM    ELEM_REQ high, waiting for host element
  // WAIT_SCALAR  element handed to scalar inverter
  typedef enum logic [1:0] {
    IDLE,
    WAIT_ELEM,
    WAIT_SCALAR
  } ntm_seq_state_t;

endpackage

/* ntm_scalar_inverter.sv */
`timescale 1ns/10ps
`include "ntm_cfg.svh"

module ntm_scalar_inverter
  import ntm_pkg::*;
#(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  logic        CLK,
  input  logic        RST,
  input  logic        START,
  input  ntm_elem_t   ELEM_IN,
  output logic        READY,
  output ntm_result_t RESULT
);

  // Coefficients of the modulus may go negative
  localparam int SW = DATA_SIZE + 3;

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  logic busy_q;

  // Operands x (value mod y) and y (modulus)
  logic [DATA_SIZE-1:0] x_q;
  logic [DATA_SIZE-1:0] y_q;

  // Working pair, u = a*x + b*y and v = c*x + d*y
  // a and c stay in 0..y-1
  logic [DATA_SIZE-1:0] u_q;
  logic [DATA_SIZE-1:0] v_q;
  logic [DATA_SIZE-1:0] a_q;
  logic [DATA_SIZE-1:0] c_q;
  logic signed [SW-1:0] b_q;
  logic signed [SW-1:0] d_q;

  ////////////////////////////////////////////////////////////
  // Step datapath
  ////////////////////////////////////////////////////////////

  logic                 small_mod;
  logic [DATA_SIZE-1:0] load_x;
  logic                 u_one;
  logic                 v_one;
  logic                 dead;
  logic                 done;
  logic                 side;
  logic                 sub;
  logic [DATA_SIZE-1:0] w;
  logic [DATA_SIZE-1:0] wa;
  logic signed [SW-1:0] wb;
  logic [DATA_SIZE:0]   a_dif;
  logic [DATA_SIZE:0]   a_sum;
  logic signed [SW-1:0] x_s;
  logic signed [SW-1:0] wb_cor;
  logic [DATA_SIZE-1:0] w_h;
  logic [DATA_SIZE-1:0] wa_h;
  logic signed [SW-1:0] wb_h;

  // Modulus 0 or 1 collapses the pair to 0/0, caught as dead
  assign small_mod = (ELEM_IN.modulo < 2);
  assign load_x    = small_mod ? '0 : ELEM_IN.value % ELEM_IN.modulo;

  // End of run decode
  assign u_one = (u_q == 1);
  assign v_one = (v_q == 1);
  // Zero leaves gcd in the other one, both even means gcd even
  assign dead  = (u_q == 0) || (v_q == 0) || (!u_q[0] && !v_q[0]);
  assign done  = u_one || v_one || dead;

  always_comb begin
    x_s  = $signed({3'b000, x_q});
    // Both odd: subtract smaller from larger, then halve
    sub  = u_q[0] && v_q[0];
    // side 1 updates v, otherwise u
    side = u_q[0] && (!v_q[0] || (u_q < v_q));
    a_dif = '0;
    if (sub) begin
      if (side) begin
        w     = v_q - u_q;
        a_dif = {1'b0, c_q} - {1'b0, a_q};
        wb    = d_q - b_q;
      end else begin
        w     = u_q - v_q;
        a_dif = {1'b0, a_q} - {1'b0, c_q};
        wb    = b_q - d_q;
      end
      wa = a_dif[DATA_SIZE-1:0];
      // Borrow: fold y into the x coefficient, x out of the y one
      if (a_dif[DATA_SIZE]) begin
        wa = wa + y_q;
        wb = wb - x_s;
      end
    end else begin
      w  = side ? v_q : u_q;
      wa = side ? c_q : a_q;
      wb = side ? d_q : b_q;
    end
    // Halve, adding (y, -x) first when a coefficient is odd
    a_sum  = {1'b0, wa} + {1'b0, y_q};
    wb_cor = wb - x_s;
    w_h    = w >> 1;
    if (!wa[0] && !wb[0]) begin
      wa_h = wa >> 1;
      wb_h = wb >>> 1;
    end else begin
      wa_h = a_sum[DATA_SIZE:1];
      wb_h = wb_cor >>> 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control and result
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q <= 1'b0;
      READY  <= 1'b0;
      RESULT <= '0;
    end else begin
      READY <= 1'b0;
      if (!busy_q) begin
        // START while busy falls through here unseen
        busy_q <= START;
      end else if (done) begin
        busy_q            <= 1'b0;
        READY             <= 1'b1;
        RESULT.no_inverse <= !(u_one || v_one);
        RESULT.value      <= u_one ? a_q : (v_one ? c_q : '0);
      end
    end
  end

  // Operand load and one Euclid step per clock
  always_ff @(posedge CLK) begin
    if (!busy_q && START) begin
      x_q <= load_x;
      y_q <= ELEM_IN.modulo;
      u_q <= load_x;
      v_q <= small_mod ? '0 : ELEM_IN.modulo;
      a_q <= 1;
      b_q <= '0;
      c_q <= '0;
      d_q <= 1;
    end else if (busy_q && !done) begin
      if (side) begin
        v_q <= w_h;
        c_q <= wa_h;
        d_q <= wb_h;
      end else begin
        u_q <= w_h;
        a_q <= wa_h;
        b_q <= wb_h;
      end
    end
  end

  // Single-cycle READY pulse
  assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else $error("scalar READY held for two cycles");

  // Latency bound from an accepted START
  assert property (@(posedge CLK) disable iff (RST)
    (START && !busy_q) |-> ##[1:`NTM_STEP_BOUND] READY)
    else $error("scalar inverter exceeded step bound");

endmodule

/* ntm_vector_inverter.sv */
`timescale 1ns/10ps
`include "ntm_cfg.svh"

module ntm_vector_inverter
  import ntm_pkg::*;
#(
  parameter int DATA_SIZE  = `NTM_DATA_SIZE,
  parameter int INDEX_SIZE = `NTM_INDEX_SIZE
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  START,
  input  logic [INDEX_SIZE-1:0] SIZE_IN,
  input  logic                  ELEM_VALID,
  input  ntm_elem_t             ELEM_IN,
  output logic                  ELEM_REQ,
  output logic                  READY,
  output logic                  RESULT_VALID,
  output ntm_result_t           RESULT
);

  ////////////////////////////////////////////////////////////
  // Sequencer state
  ////////////////////////////////////////////////////////////

  ntm_seq_state_t state_q;

  // Element index and index of last element
  logic [INDEX_SIZE-1:0] count_q;
  logic [INDEX_SIZE-1:0] last_q;

  // Element held for the scalar unit
  ntm_elem_t elem_q;

  // Scalar inverter handshake
  logic        scalar_start;
  logic        scalar_ready;
  ntm_result_t scalar_result;

  // Request straight from state, rises with RESULT_VALID
  assign ELEM_REQ = (state_q == WAIT_ELEM);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= IDLE;
      count_q      <= '0;
      last_q       <= '0;
      scalar_start <= 1'b0;
      READY        <= 1'b0;
      RESULT_VALID <= 1'b0;
      RESULT       <= '0;
    end else begin
      // Pulses by default
      scalar_start <= 1'b0;
      READY        <= 1'b0;
      RESULT_VALID <= 1'b0;
      case (state_q)
        IDLE: begin
          if (START) begin
            count_q <= '0;
            // Zero length runs one element
            last_q  <= (SIZE_IN == 0) ? '0 : SIZE_IN - 1'b1;
            state_q <= WAIT_ELEM;
          end
        end
        WAIT_ELEM: begin
          // Scalar unit starts on every element
          if (ELEM_VALID) begin
            scalar_start <= 1'b1;
            state_q      <= WAIT_SCALAR;
          end
        end
        WAIT_SCALAR: begin
          if (scalar_ready) begin
            RESULT       <= scalar_result;
            RESULT_VALID <= 1'b1;
            if (count_q == last_q) begin
              READY   <= 1'b1;
              state_q <= IDLE;
            end else begin
              count_q <= count_q + 1'b1;
              state_q <= WAIT_ELEM;
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Element capture
  always_ff @(posedge CLK) begin
    if (ELEM_REQ && ELEM_VALID) begin
      elem_q <= ELEM_IN;
    end
  end

  ////////////////////////////////////////////////////////////
  // Scalar inverter
  ////////////////////////////////////////////////////////////

  ntm_scalar_inverter #(
    .DATA_SIZE(DATA_SIZE)
  ) u_scalar_inverter (
    .CLK(CLK),
    .RST(RST),
    .START(scalar_start),
    .ELEM_IN(elem_q),
    .READY(scalar_ready),
    .RESULT(scalar_result)
  );

  // No element requested while the scalar unit is launched or finishing
  assert property (@(posedge CLK) disable iff (RST)
    ELEM_REQ |-> !(scalar_start || scalar_ready))
    else $error("element requested during scalar run");

  // Vector done only alongside its last result
  assert property (@(posedge CLK) disable iff (RST) READY |-> RESULT_VALID)
    else $error("READY without RESULT_VALID");

endmodule

/* ntm_inverter_top.sv */
`timescale 1ns/10ps
`include "ntm_cfg.svh"

module ntm_inverter_top
  import ntm_pkg::*;
#(
  parameter int DATA_SIZE  = `NTM_DATA_SIZE,
  parameter int INDEX_SIZE = `NTM_INDEX_SIZE
) (
  input  logic                  CLK,
  input  logic                  RST,
  // Vector control
  input  logic                  START,
  input  logic [INDEX_SIZE-1:0] SIZE_IN,
  output logic                  READY,
  // Element stream in
  input  logic                  ELEM_VALID,
  input  ntm_elem_t             ELEM_IN,
  output logic                  ELEM_REQ,
  // Result stream out
  output logic                  RESULT_VALID,
  output ntm_result_t           RESULT
);

  ////////////////////////////////////////////////////////////
  // Vector inverter, no extra registers at this level
  ////////////////////////////////////////////////////////////

  ntm_vector_inverter #(
    .DATA_SIZE(DATA_SIZE),
    .INDEX_SIZE(INDEX_SIZE)
  ) u_vector_inverter (
    .CLK(CLK),
    .RST(RST),
    .START(START),
    .SIZE_IN(SIZE_IN),
    .ELEM_VALID(ELEM_VALID),
    .ELEM_IN(ELEM_IN),
    .ELEM_REQ(ELEM_REQ),
    .READY(READY),
    .RESULT_VALID(RESULT_VALID),
    .RESULT(RESULT)
  );

endmodule

/* ntm_inverter_tb.sv */
`timescale 1ns/10ps
`include "ntm_cfg.svh"

module ntm_inverter_tb
  import ntm_pkg::*;
();

  localparam int DW = `NTM_DATA_SIZE;
  localparam int IW = `NTM_INDEX_SIZE;

  // One stimulus row
  // rnd rows take values and moduli per element from the LCG
  typedef struct packed {
    logic [IW-1:0]   len;
    logic            rnd;
    logic [DW-1:0]   modulo;
    logic [4*DW-1:0] vals;
  } stim_t;

  logic          CLK;
  logic          RST;
  logic          START;
  logic [IW-1:0] SIZE_IN;
  logic          ELEM_VALID;
  ntm_elem_t     ELEM_IN;
  logic          ELEM_REQ;
  logic          READY;
  logic          RESULT_VALID;
  ntm_result_t   RESULT;

  stim_t       table_q[$];
  ntm_result_t exp_q[$];
  ntm_result_t got_q[$];
  logic [31:0] lcg_state = 32'h3d13;
  bit          table_done = 1'b0;
  int          err_value;
  int          err_count;
  int          ready_seen;
  int          ready_at;

  ntm_inverter_top u_ntm_inverter_top (
    .CLK(CLK),
    .RST(RST),
    .START(START),
    .SIZE_IN(SIZE_IN),
    .READY(READY),
    .ELEM_VALID(ELEM_VALID),
    .ELEM_IN(ELEM_IN),
    .ELEM_REQ(ELEM_REQ),
    .RESULT_VALID(RESULT_VALID),
    .RESULT(RESULT)
  );

  // 8 ns clock
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Plain extended Euclid with t as the value coefficient
  function automatic ntm_result_t ref_inverse(logic [DW-1:0] value, logic [DW-1:0] modulo);
    longint      r0;
    longint      r1;
    longint      t0;
    longint      t1;
    longint      q;
    longint      tmp;
    ntm_result_t res;
    res = '0;
    if (modulo < 2) begin
      res.no_inverse = 1'b1;
    end else begin
      r0 = modulo;
      r1 = value % modulo;
      t0 = 0;
      t1 = 1;
      while (r1 != 0) begin
        q   = r0 / r1;
        tmp = r0 - q * r1;
        r0  = r1;
        r1  = tmp;
        tmp = t0 - q * t1;
        t0  = t1;
        t1  = tmp;
      end
      // r0 is now the gcd
      if (r0 != 1) begin
        res.no_inverse = 1'b1;
      end else begin
        if (t0 < 0) begin
          t0 = t0 + modulo;
        end
        res.value = t0[DW-1:0];
      end
    end
    return res;
  endfunction

  task automatic check_result(string name, ntm_result_t got, ntm_result_t exp);
    if (got !== exp) begin
      err_value++;
      $display("ERROR at %0t: %s got no_inverse=%b value=%h expected no_inverse=%b value=%h",
               $time, name, got.no_inverse, got.value, exp.no_inverse, exp.value);
    end
  endtask

  task automatic check_count(string name, logic [IW-1:0] got, logic [IW-1:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      err_value++;
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // One clock then sample outputs 1 ns later at the drive point
  task automatic step();
    @(posedge CLK);
    #1;
    if (RESULT_VALID) begin
      got_q.push_back(RESULT);
    end
    if (READY) begin
      ready_seen++;
      ready_at = got_q.size();
      // Last result and READY share a cycle
      check_flag("RESULT_VALID", RESULT_VALID, 1'b1);
    end
  endtask

  task automatic add_row(int len, bit rnd, int modulo, int v0, int v1, int v2, int v3);
    stim_t row;
    row.len    = len;
    row.rnd    = rnd;
    row.modulo = modulo;
    // Element 0 in the low slice
    row.vals   = {v3[DW-1:0], v2[DW-1:0], v1[DW-1:0], v0[DW-1:0]};
    table_q.push_back(row);
  endtask

  ////////////////////////////////////////////////////////////
  // Vector run
  ////////////////////////////////////////////////////////////

  task automatic run_row(stim_t row);
    int            n;
    logic [31:0]   r;
    logic [DW-1:0] m;
    logic [DW-1:0] v;
    n = (row.len == 0) ? 1 : row.len;
    exp_q.delete();
    got_q.delete();
    ready_seen = 0;
    ready_at   = 0;
    START   = 1'b1;
    SIZE_IN = row.len;
    step();
    START = 1'b0;
    for (int i = 0; i < n; i++) begin
      if (row.rnd) begin
        r = next_random();
        m = r[31:16];
        r = next_random();
        v = r[31:16];
      end else begin
        m = row.modulo;
        v = row.vals[i*DW +: DW];
      end
      exp_q.push_back(ref_inverse(v, m));
      while (!ELEM_REQ)
        step();
      // Late element by 0 to 3 cycles
      r = next_random();
      repeat (r[31:30]) step();
      ELEM_VALID     = 1'b1;
      ELEM_IN.modulo = m;
      ELEM_IN.value  = v;
      step();
      ELEM_VALID = 1'b0;
      if (row.rnd) begin
        // START while busy and an element nobody asked for
        START      = 1'b1;
        SIZE_IN    = '1;
        ELEM_VALID = 1'b1;
        ELEM_IN    = '1;
        step();
        START      = 1'b0;
        ELEM_VALID = 1'b0;
      end
    end
    while (ready_seen == 0)
      step();
    // Idle window to catch stray results or READY pulses
    repeat (4) step();
    check_count("result count", got_q.size(), n);
    check_count("results at READY", ready_at, n);
    check_count("READY pulses", ready_seen, 1);
    for (int i = 0; i < n && i < got_q.size(); i++)
      check_result("RESULT", got_q[i], exp_q[i]);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    RST        = 1'b1;
    START      = 1'b0;
    SIZE_IN    = '0;
    ELEM_VALID = 1'b0;
    ELEM_IN    = '0;
    err_value  = 0;
    err_count  = 0;
    // Prime moduli including the ends of the range
    add_row(4, 0, 65521, 1, 65520, 12345, 2);
    add_row(1, 0, 7, 6, 0, 0, 0);
    // Shared factors and zero values
    add_row(4, 0, 360, 0, 90, 7, 180);
    add_row(4, 0, 1024, 512, 3, 0, 1023);
    // Degenerate moduli
    add_row(2, 0, 0, 5, 0, 0, 0);
    add_row(2, 0, 1, 1, 7, 0, 0);
    // Zero length runs one element
    add_row(0, 0, 17, 3, 0, 0, 0);
    // Random vectors with per-element moduli
    add_row(5, 1, 0, 0, 0, 0, 0);
    add_row(12, 1, 0, 0, 0, 0, 0);
    table_done = 1'b1;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;
    // Quiet outputs before any START
    repeat (3) begin
      step();
      check_flag("READY", READY, 1'b0);
      check_flag("RESULT_VALID", RESULT_VALID, 1'b0);
      check_flag("ELEM_REQ", ELEM_REQ, 1'b0);
      check_result("RESULT", RESULT, '0);
    end
    foreach (table_q[k])
      run_row(table_q[k]);
    $display("Errors: value %0d, count %0d", err_value, err_count);
    if (err_value + err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Budget per element covers the scalar bound plus request, delay and result cycles
  initial begin : watchdog
    int total;
    total = 0;
    wait (table_done);
    foreach (table_q[k])
      total += (table_q[k].len == 0) ? 1 : table_q[k].len;
    repeat (total * (`NTM_STEP_BOUND + 8) + 16 * table_q.size() + 64) @(posedge CLK);
    $display("Timeout: the DUT did not finish the stimulus table in time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
ntm_pkg.sv
ntm_scalar_inverter.sv
ntm_vector_inverter.sv
ntm_inverter_top.sv
ntm_inverter_tb.sv
